// File: source/sba_pkg.sv
// Shared definitions for the system bus access unit.
// Only 32-bit accesses exist, so addresses and data share one width.
// The SBCS bit positions follow the RISC-V debug layout for the bits kept.
// All other SBCS fields read as zero.

`default_nettype none

package sba_pkg;

   // DMI side
   localparam int DMI_ADDR_W = 7;

   // Data and address width on the memory port
   localparam int DATA_W = 32;

   // Register map
   localparam logic [DMI_ADDR_W-1:0] ADDR_SBCS       = 7'h38;
   localparam logic [DMI_ADDR_W-1:0] ADDR_SBADDRESS0 = 7'h39;
   localparam logic [DMI_ADDR_W-1:0] ADDR_SBDATA0    = 7'h3C;

   // SBCS bit positions
   localparam int SBCS_READONDATA_BIT = 15;
   localparam int SBCS_AUTOINC_BIT    = 16;
   localparam int SBCS_READONADDR_BIT = 20;
   localparam int SBCS_BUSY_BIT       = 21;

   // One memory request as it travels through the FIFO
   // we=0 marks a read and wdata is then don't-care
   typedef struct packed {
      logic              we;
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } sba_req_t;

endpackage

`default_nettype wire

// File: source/sba_fifo.sv
// Synchronous request FIFO with a generic payload type.
// FIFO_DEPTH must be a power of two and at least 2.
// A push while full or a pop while empty is ignored by the logic
// and flagged by the assertions below.
// Data appears at the output one cycle after the push.

`timescale 1ns/1ps
`default_nettype none

module sba_fifo #(
   parameter int  FIFO_DEPTH = 4,
   parameter type payload_t  = logic [7:0]
) (
   input  logic     clk_sys,
   input  logic     rst_n_i,
   input  logic     push_valid_i,
   input  payload_t push_data_i,
   output logic     full_o,
   output logic     pop_valid_o,
   output payload_t pop_data_o,
   input  logic     pop_ready_i,
   output logic     empty_o
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   // Pointers carry an extra wrap bit
   logic [PTR_W:0] wr_ptr_q;
   logic [PTR_W:0] rd_ptr_q;
   payload_t       mem_q [FIFO_DEPTH];
   logic           push_en;
   logic           pop_en;

   assign empty_o = (wr_ptr_q == rd_ptr_q);
   assign full_o  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                    (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

   assign push_en = push_valid_i && !full_o;
   assign pop_en  = pop_ready_i && !empty_o;

   assign pop_valid_o = !empty_o;
   assign pop_data_o  = mem_q[rd_ptr_q[PTR_W-1:0]];

   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge clk_sys) begin
      if (push_en) begin
         mem_q[wr_ptr_q[PTR_W-1:0]] <= push_data_i;
      end
   end

   // Writer must respect full
   a_no_overflow: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      push_valid_i |-> !full_o);

   // Reader must only take what is there
   a_no_underflow: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      pop_ready_i |-> !empty_o);

endmodule

`default_nettype wire

// File: source/sba_credit_tx.sv
// Credit-based transmitter towards memory.
// Holds one request in an output register and sends it only while a
// credit is left. The memory returns one credit per consumed request.
// idle_o is high only when nothing is held and all credits are home.

`timescale 1ns/1ps
`default_nettype none

module sba_credit_tx
   import sba_pkg::*;
#(
   parameter int MEM_CREDITS = 2
) (
   input  logic              clk_sys,
   input  logic              rst_n_i,
   input  logic              pop_valid_i,
   input  sba_req_t          pop_req_i,
   output logic              pop_ready_o,
   output logic              idle_o,
   input  logic              mem_credit_i,
   output logic              mem_req_valid_o,
   output logic              mem_req_we_o,
   output logic [DATA_W-1:0] mem_req_addr_o,
   output logic [DATA_W-1:0] mem_req_wdata_o
);

   localparam int CNT_W = $clog2(MEM_CREDITS + 1);

   logic [CNT_W-1:0] credit_cnt_q;
   logic [CNT_W-1:0] credit_cnt_d;
   logic             out_valid_q;
   sba_req_t         out_req_q;
   logic             send;

   assign send = out_valid_q && (credit_cnt_q != '0);

   // Refill the output register as it drains
   assign pop_ready_o = pop_valid_i && (!out_valid_q || send);

   assign idle_o = !out_valid_q && (credit_cnt_q == CNT_W'(MEM_CREDITS));

   assign mem_req_valid_o = send;
   assign mem_req_we_o    = out_req_q.we;
   assign mem_req_addr_o  = out_req_q.addr;
   assign mem_req_wdata_o = out_req_q.wdata;

   // Returned and spent credit in one cycle cancel
   always_comb begin
      case ({mem_credit_i, send})
         2'b10:   credit_cnt_d = credit_cnt_q + 1'b1;
         2'b01:   credit_cnt_d = credit_cnt_q - 1'b1;
         default: credit_cnt_d = credit_cnt_q;
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         credit_cnt_q <= CNT_W'(MEM_CREDITS);
         out_valid_q  <= 1'b0;
      end else begin
         credit_cnt_q <= credit_cnt_d;
         if (pop_ready_o) begin
            out_valid_q <= 1'b1;
         end else if (send) begin
            out_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (pop_ready_o) begin
         out_req_q <= pop_req_i;
      end
   end

   // Memory must not return more credits than it was given
   a_credit_bound: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      credit_cnt_q <= CNT_W'(MEM_CREDITS));

endmodule

`default_nettype wire

// File: source/sba_ctrl.sv
// DMI register map and request generation for system bus access.
// Only SBCS, SBAddress0 and SBData0 are decoded; other reads return zero.
// Accesses to SBAddress0 or SBData0 are held off while the FIFO is full
// or a read is outstanding. SBCS is always accepted.
// Auto-increment steps the address by 4 after every pushed request.
// Only one read may be outstanding at a time.

`timescale 1ns/1ps
`default_nettype none

module sba_ctrl
   import sba_pkg::*;
(
   input  logic                  clk_sys,
   input  logic                  rst_n_i,
   input  logic                  dmi_req_valid_i,
   input  logic                  dmi_req_write_i,
   input  logic [DMI_ADDR_W-1:0] dmi_req_addr_i,
   input  logic [DATA_W-1:0]     dmi_req_data_i,
   output logic                  dmi_req_ready_o,
   output logic                  dmi_rsp_valid_o,
   output logic [DATA_W-1:0]     dmi_rsp_data_o,
   input  logic                  fifo_full_i,
   input  logic                  fifo_empty_i,
   input  logic                  tx_idle_i,
   output logic                  push_valid_o,
   output sba_req_t              push_req_o,
   input  logic                  mem_rsp_valid_i,
   input  logic [DATA_W-1:0]     mem_rsp_rdata_i
);

   // SBCS state
   logic              autoinc_q;
   logic              readonaddr_q;
   logic              readondata_q;
   logic              sbbusy;

   logic [DATA_W-1:0] sbaddress0_q;
   logic [DATA_W-1:0] sbdata0_q;
   logic              read_pending_q;

   logic              is_sbcs;
   logic              is_addr;
   logic              is_data;
   logic              dmi_acc;
   logic              wr_data;
   logic              rd_on_addr;
   logic              rd_on_data;
   logic [DATA_W-1:0] sbcs_rdata;
   logic [DATA_W-1:0] rdata;

   assign is_sbcs = (dmi_req_addr_i == ADDR_SBCS);
   assign is_addr = (dmi_req_addr_i == ADDR_SBADDRESS0);
   assign is_data = (dmi_req_addr_i == ADDR_SBDATA0);

   // Hold off bus-facing registers while the path is busy
   assign dmi_req_ready_o = !((is_addr || is_data) && (fifo_full_i || read_pending_q));
   assign dmi_acc         = dmi_req_valid_i && dmi_req_ready_o;

   assign wr_data    = dmi_acc && dmi_req_write_i && is_data;
   assign rd_on_addr = dmi_acc && dmi_req_write_i && is_addr && readonaddr_q;
   assign rd_on_data = dmi_acc && !dmi_req_write_i && is_data && readondata_q;

   assign push_valid_o     = wr_data || rd_on_addr || rd_on_data;
   assign push_req_o.we    = wr_data;
   // New address is used directly on read-on-address
   assign push_req_o.addr  = rd_on_addr ? dmi_req_data_i : sbaddress0_q;
   assign push_req_o.wdata = wr_data ? dmi_req_data_i : '0;

   assign sbbusy = !fifo_empty_i || !tx_idle_i || read_pending_q;

   always_comb begin
      sbcs_rdata                      = '0;
      sbcs_rdata[SBCS_BUSY_BIT]       = sbbusy;
      sbcs_rdata[SBCS_READONADDR_BIT] = readonaddr_q;
      sbcs_rdata[SBCS_AUTOINC_BIT]    = autoinc_q;
      sbcs_rdata[SBCS_READONDATA_BIT] = readondata_q;
   end

   always_comb begin
      if (is_sbcs) begin
         rdata = sbcs_rdata;
      end else if (is_addr) begin
         rdata = sbaddress0_q;
      end else if (is_data) begin
         rdata = sbdata0_q;
      end else begin
         rdata = '0;
      end
   end

   // Register updates
   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         autoinc_q      <= 1'b0;
         readonaddr_q   <= 1'b0;
         readondata_q   <= 1'b0;
         sbaddress0_q   <= '0;
         sbdata0_q      <= '0;
         read_pending_q <= 1'b0;
      end else begin
         if (dmi_acc && dmi_req_write_i && is_sbcs) begin
            autoinc_q    <= dmi_req_data_i[SBCS_AUTOINC_BIT];
            readonaddr_q <= dmi_req_data_i[SBCS_READONADDR_BIT];
            readondata_q <= dmi_req_data_i[SBCS_READONDATA_BIT];
         end

         if (dmi_acc && dmi_req_write_i && is_addr) begin
            sbaddress0_q <= (rd_on_addr && autoinc_q) ? dmi_req_data_i + DATA_W'(4)
                                                      : dmi_req_data_i;
         end else if (push_valid_o && autoinc_q) begin
            sbaddress0_q <= sbaddress0_q + DATA_W'(4);
         end

         // Read data lands here
         if (mem_rsp_valid_i) begin
            sbdata0_q <= mem_rsp_rdata_i;
         end else if (wr_data) begin
            sbdata0_q <= dmi_req_data_i;
         end

         if (rd_on_addr || rd_on_data) begin
            read_pending_q <= 1'b1;
         end else if (mem_rsp_valid_i) begin
            read_pending_q <= 1'b0;
         end
      end
   end

   // DMI response one cycle after an accepted read
   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         dmi_rsp_valid_o <= 1'b0;
      end else begin
         dmi_rsp_valid_o <= dmi_acc && !dmi_req_write_i;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (dmi_acc && !dmi_req_write_i) begin
         dmi_rsp_data_o <= rdata;
      end
   end

   a_no_push_when_full: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      push_valid_o |-> !fifo_full_i);

   // Memory answers only reads that were issued
   a_rsp_only_when_pending: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      mem_rsp_valid_i |-> read_pending_q);

endmodule

`default_nettype wire

// File: source/sba_top.sv
// System bus access unit top level.
// DMI host port on one side, credit-based 32-bit memory port on the other.
// FIFO_DEPTH must be a power of two. MEM_CREDITS must match the number
// of requests the memory can accept before returning a credit.
// Read responses have no back-pressure.

`timescale 1ns/1ps
`default_nettype none

module sba_top
   import sba_pkg::*;
#(
   parameter int FIFO_DEPTH  = 4,
   parameter int MEM_CREDITS = 2
) (
   input  logic                  clk_sys,
   input  logic                  rst_n_i,
   // DMI host port
   input  logic                  dmi_req_valid_i,
   input  logic                  dmi_req_write_i,
   input  logic [DMI_ADDR_W-1:0] dmi_req_addr_i,
   input  logic [DATA_W-1:0]     dmi_req_data_i,
   output logic                  dmi_req_ready_o,
   output logic                  dmi_rsp_valid_o,
   output logic [DATA_W-1:0]     dmi_rsp_data_o,
   // Memory port
   output logic                  mem_req_valid_o,
   output logic                  mem_req_we_o,
   output logic [DATA_W-1:0]     mem_req_addr_o,
   output logic [DATA_W-1:0]     mem_req_wdata_o,
   input  logic                  mem_credit_i,
   input  logic                  mem_rsp_valid_i,
   input  logic [DATA_W-1:0]     mem_rsp_rdata_i
);

   logic     push_valid;
   sba_req_t push_req;
   logic     fifo_full;
   logic     fifo_empty;
   logic     pop_valid;
   sba_req_t pop_req;
   logic     pop_ready;
   logic     tx_idle;

   sba_ctrl u_ctrl (
      .clk_sys         (clk_sys),
      .rst_n_i         (rst_n_i),
      .dmi_req_valid_i (dmi_req_valid_i),
      .dmi_req_write_i (dmi_req_write_i),
      .dmi_req_addr_i  (dmi_req_addr_i),
      .dmi_req_data_i  (dmi_req_data_i),
      .dmi_req_ready_o (dmi_req_ready_o),
      .dmi_rsp_valid_o (dmi_rsp_valid_o),
      .dmi_rsp_data_o  (dmi_rsp_data_o),
      .fifo_full_i     (fifo_full),
      .fifo_empty_i    (fifo_empty),
      .tx_idle_i       (tx_idle),
      .push_valid_o    (push_valid),
      .push_req_o      (push_req),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_rdata_i (mem_rsp_rdata_i)
   );

   sba_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .payload_t  (sba_req_t)
   ) u_fifo (
      .clk_sys      (clk_sys),
      .rst_n_i      (rst_n_i),
      .push_valid_i (push_valid),
      .push_data_i  (push_req),
      .full_o       (fifo_full),
      .pop_valid_o  (pop_valid),
      .pop_data_o   (pop_req),
      .pop_ready_i  (pop_ready),
      .empty_o      (fifo_empty)
   );

   sba_credit_tx #(
      .MEM_CREDITS (MEM_CREDITS)
   ) u_tx (
      .clk_sys         (clk_sys),
      .rst_n_i         (rst_n_i),
      .pop_valid_i     (pop_valid),
      .pop_req_i       (pop_req),
      .pop_ready_o     (pop_ready),
      .idle_o          (tx_idle),
      .mem_credit_i    (mem_credit_i),
      .mem_req_valid_o (mem_req_valid_o),
      .mem_req_we_o    (mem_req_we_o),
      .mem_req_addr_o  (mem_req_addr_o),
      .mem_req_wdata_o (mem_req_wdata_o)
   );

endmodule

`default_nettype wire

// File: test/tb_mem_model.sv
// Memory model behind the credit-based request port.
// Credits come back strictly in request order, each after 0 to 5 cycles.
// Read data is taken when the read arrives and returned with its credit.
// Unwritten words read back as the inverted address.
// All outputs change on the falling clock edge.

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
   import sba_pkg::*;
(
   input  logic              clk_sys,
   input  logic              rst_n_i,
   input  logic              hold_credits_i,
   input  logic              mem_req_valid_i,
   input  logic              mem_req_we_i,
   input  logic [DATA_W-1:0] mem_req_addr_i,
   input  logic [DATA_W-1:0] mem_req_wdata_i,
   output logic              mem_credit_o,
   output logic              mem_rsp_valid_o,
   output logic [DATA_W-1:0] mem_rsp_rdata_o,
   output int                outstanding_o
);

   logic [DATA_W-1:0] words [logic [DATA_W-1:0]];
   sba_req_t          pend_q [$];
   int unsigned       delay_q [$];

   initial begin
      mem_credit_o    = 1'b0;
      mem_rsp_valid_o = 1'b0;
      mem_rsp_rdata_o = '0;
      outstanding_o   = 0;
   end

   always @(negedge clk_sys) begin
      sba_req_t head_req;
      sba_req_t new_req;
      mem_credit_o    = 1'b0;
      mem_rsp_valid_o = 1'b0;
      if (!rst_n_i) begin
         pend_q.delete();
         delay_q.delete();
      end else begin
         // Retire the oldest request first, so a new one waits at least a cycle
         if (pend_q.size() > 0) begin
            if (delay_q[0] == 0 && !hold_credits_i) begin
               head_req = pend_q.pop_front();
               void'(delay_q.pop_front());
               mem_credit_o    = 1'b1;
               mem_rsp_valid_o = !head_req.we;
               mem_rsp_rdata_o = head_req.wdata;
            end else if (delay_q[0] > 0) begin
               delay_q[0] = delay_q[0] - 1;
            end
         end
         if (mem_req_valid_i) begin
            new_req.we    = mem_req_we_i;
            new_req.addr  = mem_req_addr_i;
            new_req.wdata = mem_req_wdata_i;
            if (mem_req_we_i) begin
               words[mem_req_addr_i] = mem_req_wdata_i;
            end else if (words.exists(mem_req_addr_i)) begin
               new_req.wdata = words[mem_req_addr_i];
            end else begin
               new_req.wdata = ~mem_req_addr_i;
            end
            pend_q.push_back(new_req);
            delay_q.push_back($urandom % 6);
         end
      end
      // Requests sent and not yet credited back
      outstanding_o = pend_q.size();
   end

endmodule

`default_nettype wire

// File: test/tb_sba_top.sv
// Testbench for the system bus access unit.
// DMI inputs change on the falling edge, and so does all reference state.
// Concurrent assertions on the rising edge compare the DUT against it.
// Expected memory requests are derived from the register rules of SBCS,
// SBAddress0 and SBData0. Random data and delays use one seeded stream.

`timescale 1ns/1ps
`default_nettype none

module tb_sba_top
   import sba_pkg::*;
();

   localparam int FIFO_DEPTH  = 4;
   localparam int MEM_CREDITS = 2;
   localparam int RAND_SEED   = 52877;
   localparam int NUM_OPS     = 100;
   localparam int TIMEOUT_CYC = NUM_OPS * 40 + 500;
   localparam int MAX_REQ     = 64;
   localparam int BURST_LEN   = 6;
   localparam int HOLD_WRITES = 10;
   localparam int HOLD_CYCLES = 40;

   logic clk_sys, rst_n_i, hold_credits, all_done, rsp_due;
   logic dmi_req_valid_i, dmi_req_write_i, dmi_req_ready_o, dmi_rsp_valid_o;
   logic [DMI_ADDR_W-1:0] dmi_req_addr_i;
   logic [DATA_W-1:0] dmi_req_data_i, dmi_rsp_data_o, rsp_mask, rsp_exp;
   logic mem_req_valid_o, mem_req_we_o, mem_credit_i, mem_rsp_valid_i;
   logic [DATA_W-1:0] mem_req_addr_o, mem_req_wdata_o, mem_rsp_rdata_i;
   int outstanding;

   // Reference model
   logic [DATA_W-1:0] ref_addr;
   logic ref_autoinc, ref_readonaddr, ref_readondata;
   logic exp_we [MAX_REQ];
   logic [DATA_W-1:0] exp_addr [MAX_REQ];
   logic [DATA_W-1:0] exp_wdata [MAX_REQ];
   logic [DATA_W-1:0] burst_words [BURST_LEN];
   int exp_cnt = 0;
   int sent_cnt = 0;

   sba_top #(.FIFO_DEPTH(FIFO_DEPTH), .MEM_CREDITS(MEM_CREDITS)) u_dut (
      .clk_sys(clk_sys), .rst_n_i(rst_n_i),
      .dmi_req_valid_i(dmi_req_valid_i), .dmi_req_write_i(dmi_req_write_i),
      .dmi_req_addr_i(dmi_req_addr_i), .dmi_req_data_i(dmi_req_data_i),
      .dmi_req_ready_o(dmi_req_ready_o), .dmi_rsp_valid_o(dmi_rsp_valid_o),
      .dmi_rsp_data_o(dmi_rsp_data_o), .mem_req_valid_o(mem_req_valid_o),
      .mem_req_we_o(mem_req_we_o), .mem_req_addr_o(mem_req_addr_o),
      .mem_req_wdata_o(mem_req_wdata_o), .mem_credit_i(mem_credit_i),
      .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_rdata_i(mem_rsp_rdata_i)
   );

   tb_mem_model u_mem (
      .clk_sys(clk_sys), .rst_n_i(rst_n_i), .hold_credits_i(hold_credits),
      .mem_req_valid_i(mem_req_valid_o), .mem_req_we_i(mem_req_we_o),
      .mem_req_addr_i(mem_req_addr_o), .mem_req_wdata_i(mem_req_wdata_o),
      .mem_credit_o(mem_credit_i), .mem_rsp_valid_o(mem_rsp_valid_i),
      .mem_rsp_rdata_o(mem_rsp_rdata_i), .outstanding_o(outstanding)
   );

   initial begin
      clk_sys = 1'b0;
      forever #2 clk_sys = ~clk_sys;
   end

   task automatic abort_run();
      $display("test failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic report_mismatch(input string what);
      $display("ERR t=%0t %s", $time, what);
      abort_run();
   endtask

   task automatic expect_req(input logic we, input logic [DATA_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata);
      exp_we[exp_cnt]    = we;
      exp_addr[exp_cnt]  = addr;
      exp_wdata[exp_cnt] = wdata;
      exp_cnt++;
      if (ref_autoinc) begin
         ref_addr = ref_addr + 32'd4;
      end
   endtask

   // Register rules applied once an access is accepted
   task automatic update_model(input logic wr, input logic [DMI_ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
      if (wr && addr == ADDR_SBCS) begin
         ref_autoinc    = data[SBCS_AUTOINC_BIT];
         ref_readonaddr = data[SBCS_READONADDR_BIT];
         ref_readondata = data[SBCS_READONDATA_BIT];
      end else if (wr && addr == ADDR_SBADDRESS0) begin
         ref_addr = data;
         if (ref_readonaddr) begin
            expect_req(1'b0, ref_addr, '0);
         end
      end else if (wr && addr == ADDR_SBDATA0) begin
         expect_req(1'b1, ref_addr, data);
      end else if (!wr && addr == ADDR_SBDATA0 && ref_readondata) begin
         expect_req(1'b0, ref_addr, '0);
      end
   endtask

   // Starts and ends on a falling edge; mask selects the checked read bits
   task automatic dmi_access(input logic wr, input logic [DMI_ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] mask,
                             input logic [DATA_W-1:0] expv, output logic [DATA_W-1:0] rdata);
      dmi_req_valid_i = 1'b1;
      dmi_req_write_i = wr;
      dmi_req_addr_i  = addr;
      dmi_req_data_i  = data;
      #1;
      while (!dmi_req_ready_o) begin
         @(negedge clk_sys);
         #1;
      end
      @(negedge clk_sys);
      dmi_req_valid_i = 1'b0;
      update_model(wr, addr, data);
      rdata = '0;
      if (!wr) begin
         rsp_mask = mask;
         rsp_exp  = expv;
         rsp_due  = 1'b1;
         #1;
         rdata = dmi_rsp_data_o;
         @(negedge clk_sys);
         rsp_due = 1'b0;
      end
   endtask

   task automatic dmi_write(input logic [DMI_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      logic [DATA_W-1:0] unused_rd;
      dmi_access(1'b1, addr, data, '0, '0, unused_rd);
   endtask

   // Read SBCS until sbbusy clears, checking the other bits on the way
   task automatic poll_idle();
      logic [DATA_W-1:0] sbcs;
      logic [DATA_W-1:0] cfg;
      sbcs = '1;
      while (sbcs[SBCS_BUSY_BIT]) begin
         cfg = '0;
         cfg[SBCS_AUTOINC_BIT]    = ref_autoinc;
         cfg[SBCS_READONADDR_BIT] = ref_readonaddr;
         cfg[SBCS_READONDATA_BIT] = ref_readondata;
         dmi_access(1'b0, ADDR_SBCS, '0, ~(32'd1 << SBCS_BUSY_BIT), cfg, sbcs);
      end
   endtask

   always @(negedge clk_sys) begin
      if (rst_n_i && mem_req_valid_o) begin
         sent_cnt = sent_cnt + 1;
      end
   end

   a_reset_idle: assert property (@(posedge clk_sys)
      $rose(rst_n_i) |-> !mem_req_valid_o && dmi_req_ready_o)
      else report_mismatch("outputs not idle after reset");
   a_sbcs_ready: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      dmi_req_valid_i && dmi_req_addr_i == ADDR_SBCS |-> dmi_req_ready_o)
      else report_mismatch("SBCS access held off");
   a_rsp_timing: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      rsp_due == dmi_rsp_valid_o)
      else report_mismatch("DMI response not exactly one cycle after read");
   a_rsp_data: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      rsp_due |-> (dmi_rsp_data_o & rsp_mask) == rsp_exp)
      else report_mismatch($sformatf("DMI read data %h, expected %h under mask %h",
                                     dmi_rsp_data_o, rsp_exp, rsp_mask));
   a_req_match: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      mem_req_valid_o |-> sent_cnt <= exp_cnt && mem_req_we_o == exp_we[sent_cnt-1]
         && mem_req_addr_o == exp_addr[sent_cnt-1]
         && (!mem_req_we_o || mem_req_wdata_o == exp_wdata[sent_cnt-1]))
      else report_mismatch($sformatf("memory request %0d we=%0b addr=%h wdata=%h unexpected",
                                     sent_cnt - 1, mem_req_we_o, mem_req_addr_o,
                                     mem_req_wdata_o));
   a_credit_bound: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      outstanding <= MEM_CREDITS)
      else report_mismatch($sformatf("%0d requests outstanding at memory", outstanding));
   a_full_holds_off: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      dmi_req_valid_i && dmi_req_addr_i == ADDR_SBDATA0 && exp_cnt - sent_cnt > FIFO_DEPTH
         |-> !dmi_req_ready_o)
      else report_mismatch("SBData0 access accepted with full request path");
   a_drained: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      all_done |-> sent_cnt == exp_cnt && outstanding == 0)
      else report_mismatch($sformatf("%0d of %0d requests reached memory", sent_cnt, exp_cnt));

   initial begin
      repeat (TIMEOUT_CYC) @(posedge clk_sys);
      $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
               TIMEOUT_CYC);
      abort_run();
   end

   initial begin
      logic [DATA_W-1:0] rd;
      int i;
      void'($urandom(RAND_SEED));
      rst_n_i = 1'b0;
      dmi_req_valid_i = 1'b0;
      dmi_req_write_i = 1'b0;
      // Ready after reset then depends on the FIFO and read state
      dmi_req_addr_i  = ADDR_SBDATA0;
      dmi_req_data_i  = '0;
      {hold_credits, all_done, rsp_due, rsp_mask, rsp_exp} = '0;
      {ref_addr, ref_autoinc, ref_readonaddr, ref_readondata} = '0;
      repeat (16) @(negedge clk_sys);
      rst_n_i = 1'b1;
      @(negedge clk_sys);
      dmi_access(1'b0, ADDR_SBCS, '0, '1, '0, rd);

      // Auto-increment burst
      dmi_write(ADDR_SBCS, 32'd1 << SBCS_AUTOINC_BIT);
      dmi_write(ADDR_SBADDRESS0, 32'h0000_1000);
      for (i = 0; i < BURST_LEN; i++) begin
         burst_words[i] = $urandom;
         dmi_write(ADDR_SBDATA0, burst_words[i]);
      end
      poll_idle();

      // Fixed address, then address read-back
      dmi_write(ADDR_SBCS, '0);
      dmi_write(ADDR_SBADDRESS0, 32'h0000_2000);
      repeat (3) dmi_write(ADDR_SBDATA0, $urandom);
      poll_idle();
      dmi_access(1'b0, ADDR_SBADDRESS0, '0, '1, ref_addr, rd);

      // Read the burst back through sbreadonaddr and sbreadondata
      dmi_write(ADDR_SBCS, (32'd1 << SBCS_AUTOINC_BIT) | (32'd1 << SBCS_READONADDR_BIT)
                           | (32'd1 << SBCS_READONDATA_BIT));
      dmi_write(ADDR_SBADDRESS0, 32'h0000_1000);
      for (i = 0; i < BURST_LEN; i++) begin
         poll_idle();
         dmi_access(1'b0, ADDR_SBDATA0, '0, '1, burst_words[i], rd);
      end
      poll_idle();

      // Withheld credits fill the FIFO
      dmi_write(ADDR_SBCS, 32'd1 << SBCS_AUTOINC_BIT);
      dmi_write(ADDR_SBADDRESS0, 32'h0000_3000);
      #1;
      hold_credits = 1'b1;
      @(negedge clk_sys);
      fork
         begin
            for (i = 0; i < HOLD_WRITES; i++) begin
               dmi_write(ADDR_SBDATA0, $urandom);
            end
         end
         begin
            repeat (HOLD_CYCLES) @(negedge clk_sys);
            #1;
            hold_credits = 1'b0;
         end
      join
      poll_idle();

      all_done = 1'b1;
      @(negedge clk_sys);
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
source/sba_pkg.sv
source/sba_fifo.sv
source/sba_credit_tx.sv
source/sba_ctrl.sv
source/sba_top.sv
test/tb_mem_model.sv
test/tb_sba_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the SBA testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_sba_top -f all.f

# The simulator exits non-zero on a failure; the log decides the result
./obj_dir/Vtb_sba_top | tee sim.log || true

if grep -qx "test passed" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
